// ==== vlog.f ====
+incdir+src
+incdir+sim
src/execPkg.sv
src/reservationStation.sv
src/execUnit.sv
src/execCluster.sv
sim/execClusterTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execution cluster testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    -f vlog.f --top-module execClusterTb -Mdir obj_dir -o execClusterTb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/execClusterTb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// ==== sim/tbRefModel.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef logic [DataW-1:0] word_t;

// Signed compare done as unsigned with both sign bits flipped.
function automatic logic lessSigned(input word_t a, input word_t b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
endfunction

function automatic word_t shiftRightArith(input word_t a, input logic [4:0] sh);
    logic [63:0] wide;
    wide = {{32{a[31]}}, a} >> sh;
    return wide[31:0];
endfunction

function automatic word_t aluResult(input aluOp_e op, input word_t pc, input word_t a,
                                   input word_t b, input word_t imm);
    case (op)
        LUI:       return imm;
        AUIPC:     return pc + imm;
        JAL, JALR: return pc + 32'd4;
        ADDI:      return a + imm;
        SLTI:      return {31'b0, lessSigned(a, imm)};
        SLTIU:     return {31'b0, a < imm};
        XORI:      return a ^ imm;
        ORI:       return a | imm;
        ANDI:      return a & imm;
        SLLI:      return a << imm[4:0];
        SRLI:      return a >> imm[4:0];
        SRAI:      return shiftRightArith(a, imm[4:0]);
        ADD:       return a + b;
        SUB:       return a - b;
        SLL:       return a << b[4:0];
        SLT:       return {31'b0, lessSigned(a, b)};
        SLTU:      return {31'b0, a < b};
        XOR:       return a ^ b;
        SRL:       return a >> b[4:0];
        SRA:       return shiftRightArith(a, b[4:0]);
        OR:        return a | b;
        AND:       return a & b;
        default:   return 32'd0;
    endcase
endfunction

function automatic logic branchTaken(input aluOp_e op, input word_t a, input word_t b);
    case (op)
        BEQ:       return a == b;
        BNE:       return a != b;
        BLT:       return lessSigned(a, b);
        BGE:       return !lessSigned(a, b);
        BLTU:      return a < b;
        BGEU:      return !(a < b);
        JAL, JALR: return 1'b1;
        default:   return 1'b0;
    endcase
endfunction

function automatic word_t nextPc(input aluOp_e op, input word_t pc, input word_t a,
                                 input word_t b, input word_t imm);
    if (op == JALR) begin
        return (a + imm) & ~32'd1;
    end
    if (branchTaken(op, a, b)) begin
        return pc + imm;
    end
    return pc + 32'd4;
endfunction

function automatic cdb_t expectedCdb(input logic [NickW-1:0] nick, input aluOp_e op,
                                     input word_t pc, input word_t a, input word_t b,
                                     input word_t imm);
    return '{valid: 1'b1, nick: nick, data: aluResult(op, pc, a, b, imm),
             taken: branchTaken(op, a, b), target: nextPc(op, pc, a, b, imm)};
endfunction

`endif

// ==== sim/execClusterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module execClusterTb
    import execPkg::*;
();

    `include "tbRefModel.svh"

    localparam int Window = 100;
    localparam int NumNick = 1 << NickW;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t imm;
    } vec_t;

    logic      clk;
    logic      rst;
    logic      rdy;
    logic      dispatchValid;
    dispatch_t dispatchIn;
    logic      dispatchReady;
    cdb_t      extCdb;
    cdb_t      cdbOut;

    // Scoreboard indexed by nickname.
    cdb_t               expected [NumNick];
    logic [NumNick-1:0] pending;
    cdb_t               heldCdb;
    logic               edgeRdy;
    int                 seed;
    vec_t               vecs [6];
    word_t              tagVal [4];

    execCluster execCluster_inst (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .dispatchValid (dispatchValid),
        .dispatchIn    (dispatchIn),
        .dispatchReady (dispatchReady),
        .extCdb        (extCdb),
        .cdbOut        (cdbOut)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic stopRun(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped on the first error.");
    endtask

    task automatic checkCdb(input string name, input cdb_t got, input cdb_t want);
        if (got !== want) begin
            stopRun({$sformatf("FAIL %s: got valid %h nick %h data %h taken %h target %h,",
                               name, got.valid, got.nick, got.data, got.taken, got.target),
                     $sformatf(" expected valid %h nick %h data %h taken %h target %h",
                               want.valid, want.nick, want.data, want.taken, want.target)});
        end
    endtask

    task automatic checkReady(input logic want);
        if (dispatchReady !== want) begin
            stopRun($sformatf("FAIL dispatchReady: got %h, expected %h", dispatchReady, want));
        end
    endtask

    // A result counts once, on an edge where rdy was high.
    always begin
        @(posedge clk);
        edgeRdy = rdy;
        #1;
        if (!rst) begin
            if (!edgeRdy) begin
                checkCdb("cdbOut", cdbOut, heldCdb);
            end else if (cdbOut.valid && !pending[cdbOut.nick]) begin
                stopRun($sformatf("Nickname %0d on cdbOut is unknown or repeated", cdbOut.nick));
            end else if (cdbOut.valid) begin
                checkCdb("cdbOut", cdbOut, expected[cdbOut.nick]);
                pending[cdbOut.nick] = 1'b0;
            end
            heldCdb = cdbOut;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic operand_t readyOperand(input word_t v);
        return '{ready: 1'b1, nick: '0, data: v};
    endfunction

    function automatic operand_t waitOperand(input int nick);
        return '{ready: 1'b0, nick: NickW'(nick), data: '0};
    endfunction

    // The a and b values are what the operands hold once they are ready.
    task automatic sendOp(input word_t pc, input aluOp_e op, input word_t imm, input int rd,
                          input operand_t rs1, input operand_t rs2, input word_t a,
                          input word_t b);
        int t;
        t = 0;
        while (pending[rd]) begin
            @(posedge clk);
            #2;
            t++;
            if (t > Window) begin
                stopRun($sformatf("Timed out waiting for nickname %0d to retire", rd));
            end
        end
        expected[rd] = expectedCdb(NickW'(rd), op, pc, a, b, imm);
        pending[rd] = 1'b1;
        dispatchIn = '{pc: pc, op: op, imm: imm, rd: NickW'(rd), rs1: rs1, rs2: rs2};
        dispatchValid = 1'b1;
        t = 0;
        @(negedge clk);
        while (!(dispatchReady && rdy)) begin
            t++;
            if (t > Window) begin
                stopRun("Timed out waiting for the station to accept an entry");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        dispatchValid = 1'b0;
    endtask

    task automatic injectExt(input int nick, input word_t data);
        extCdb = '{valid: 1'b1, nick: NickW'(nick), data: data, taken: 1'b0, target: '0};
        @(posedge clk);
        #2;
        extCdb.valid = 1'b0;
    endtask

    task automatic waitRetired(input int nick);
        int t;
        t = 0;
        while (pending[nick]) begin
            @(posedge clk);
            #2;
            t++;
            if (t > Window) begin
                stopRun($sformatf("Timed out waiting for the result of nickname %0d", nick));
            end
        end
    endtask

    // One extra edge lets the last broadcast drop off the bus.
    task automatic waitIdle();
        int t;
        t = 0;
        while (pending != '0) begin
            @(posedge clk);
            #2;
            t++;
            if (t > Window) begin
                stopRun($sformatf("Timed out with nicknames %h still outstanding", pending));
            end
        end
        @(posedge clk);
        #2;
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        word_t a;
        word_t b;
        word_t c;
        word_t p0;
        word_t p1;
        int    n;
        seed = 32'h950236ff;
        rst = 1'b1;
        rdy = 1'b1;
        dispatchValid = 1'b0;
        dispatchIn = '0;
        extCdb = '0;
        pending = '0;
        heldCdb = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        checkReady(1'b1);
        @(posedge clk);
        #2;

        // Edge cases first, then random rows. Every op runs on every row.
        vecs[0] = '{32'h0000_0005, 32'h0000_0005, 32'h0000_0010};
        vecs[1] = '{32'h8000_0000, 32'h0000_0001, 32'hFFFF_FFFF};
        vecs[2] = '{32'hFFFF_FFFE, 32'h8000_001F, 32'h0000_07FF};
        vecs[3] = '{32'h7FFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_F800};
        for (int v = 4; v < 6; v++) begin
            vecs[v].a = $random(seed);
            vecs[v].b = $random(seed);
            vecs[v].imm = $random(seed);
        end
        n = 0;
        foreach (vecs[v]) begin
            for (int o = 0; o <= int'(AND); o++) begin
                sendOp(32'h1000 + 32'(n * 4), aluOp_e'(o), vecs[v].imm, n % 8,
                       readyOperand(vecs[v].a), readyOperand(vecs[v].b), vecs[v].a, vecs[v].b);
                n++;
            end
        end
        waitIdle();

        // Consumers go in before their producer so they must wait on cdbOut.
        a = $random(seed);
        b = $random(seed);
        c = $random(seed);
        p0 = aluResult(ADD, 32'h2000, a, b, '0);
        p1 = aluResult(SUB, 32'h2004, p0, c, '0);
        sendOp(32'h2008, XOR, '0, 2, waitOperand(1), waitOperand(0), p1, p0);
        sendOp(32'h2004, SUB, '0, 1, waitOperand(0), readyOperand(c), p0, c);
        sendOp(32'h2000, ADD, '0, 0, readyOperand(a), readyOperand(b), a, b);
        waitIdle();

        // Operands from outside the cluster.
        a = $random(seed);
        b = $random(seed);
        sendOp(32'h3000, ADDI, 32'h0000_0123, 3, waitOperand(12), readyOperand('0), a, '0);
        sendOp(32'h3004, AND, '0, 4, waitOperand(12), waitOperand(13), a, b);
        repeat (20) @(posedge clk);
        #2;
        if (!pending[3] || !pending[4]) begin
            stopRun("An entry completed before its operand was delivered");
        end
        injectExt(12, a);
        waitRetired(3);
        repeat (10) @(posedge clk);
        #2;
        if (!pending[4]) begin
            stopRun("Nickname 4 completed while still waiting on tag 13");
        end
        injectExt(13, b);
        waitIdle();

        // Fill all eight slots, then hold a ninth entry until a slot frees.
        for (int i = 0; i < 4; i++) begin
            tagVal[i] = $random(seed);
        end
        for (int i = 0; i < 8; i++) begin
            c = $random(seed);
            sendOp(32'h4000 + 32'(i * 4), ADD, '0, i, waitOperand(8 + i % 4), readyOperand(c),
                   tagVal[i % 4], c);
        end
        fork
            sendOp(32'h4020, SLTU, '0, 12, readyOperand(32'h1), readyOperand(32'h2),
                   32'h1, 32'h2);
            begin
                repeat (3) begin
                    @(negedge clk);
                    checkReady(1'b0);
                end
                @(posedge clk);
                #2;
                for (int i = 0; i < 4; i++) begin
                    injectExt(8 + i, tagVal[i]);
                end
            end
        join
        waitIdle();
        @(negedge clk);
        checkReady(1'b1);
        @(posedge clk);
        #2;

        // Stall with results in flight.
        fork
            for (int i = 0; i < 6; i++) begin
                a = $random(seed);
                b = $random(seed);
                sendOp(32'h5000 + 32'(i * 4), aluOp_e'(int'(ADD) + i), '0, i,
                       readyOperand(a), readyOperand(b), a, b);
            end
            begin
                repeat (3) @(posedge clk);
                #2;
                rdy = 1'b0;
                repeat (6) @(posedge clk);
                #2;
                rdy = 1'b1;
            end
        join
        waitIdle();

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/execCluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module execCluster
    import execPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    input  logic      dispatchValid,
    input  dispatch_t dispatchIn,
    output logic      dispatchReady,
    input  cdb_t      extCdb,
    output cdb_t      cdbOut
);

    logic   issueValid;
    issue_t issueOut;

    // The unit's own result loops back as the local wakeup bus.
    reservationStation reservationStation_inst (
        .clk           (clk),
        .rst           (rst),
        .rdy           (rdy),
        .dispatchValid (dispatchValid),
        .dispatchIn    (dispatchIn),
        .dispatchReady (dispatchReady),
        .localCdb      (cdbOut),
        .extCdb        (extCdb),
        .issueValid    (issueValid),
        .issueOut      (issueOut)
    );

    execUnit execUnit_inst (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueValid (issueValid),
        .issueIn    (issueOut),
        .cdbOut     (cdbOut)
    );

endmodule

`default_nettype wire

// ==== src/execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execUnit
    import execPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   issueValid,
    input  issue_t issueIn,
    output cdb_t   cdbOut
);

    logic [DataW-1:0] rs1;
    logic [DataW-1:0] rs2;
    logic [DataW-1:0] pcPlus4;
    logic [DataW-1:0] pcPlusImm;
    logic [DataW-1:0] jalrSum;
    logic [4:0]       regShamt;
    logic [4:0]       immShamt;
    logic             brCond;

    logic [DataW-1:0] resData;
    logic             resTaken;
    logic [DataW-1:0] resTarget;

    logic             validQ;
    logic [NickW-1:0] nickQ;
    logic [DataW-1:0] dataQ;
    logic             takenQ;
    logic [DataW-1:0] targetQ;

    assign rs1       = issueIn.rs1Data;
    assign rs2       = issueIn.rs2Data;
    assign pcPlus4   = issueIn.pc + DataW'(4);
    assign pcPlusImm = issueIn.pc + issueIn.imm;
    assign jalrSum   = rs1 + issueIn.imm;
    assign regShamt  = rs2[4:0];
    assign immShamt  = issueIn.imm[4:0];

    ////////////////////////////////////////
    // Branch compare
    ////////////////////////////////////////

    always_comb begin
        case (issueIn.op)
            BEQ:     brCond = (rs1 == rs2);
            BNE:     brCond = (rs1 != rs2);
            BLT:     brCond = ($signed(rs1) < $signed(rs2));
            BGE:     brCond = ($signed(rs1) >= $signed(rs2));
            BLTU:    brCond = (rs1 < rs2);
            BGEU:    brCond = (rs1 >= rs2);
            default: brCond = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Result
    ////////////////////////////////////////

    // Default is a plain ALU op that falls through to pc+4.
    always_comb begin
        resData   = '0;
        resTaken  = 1'b0;
        resTarget = pcPlus4;
        case (issueIn.op)
            LUI:   resData = issueIn.imm;
            AUIPC: resData = pcPlusImm;
            JAL: begin
                resData   = pcPlus4;
                resTaken  = 1'b1;
                resTarget = pcPlusImm;
            end
            JALR: begin
                resData   = pcPlus4;
                resTaken  = 1'b1;
                resTarget = {jalrSum[DataW-1:1], 1'b0};
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                resTaken  = brCond;
                resTarget = brCond ? pcPlusImm : pcPlus4;
            end
            ADDI:  resData = rs1 + issueIn.imm;
            SLTI:  resData = DataW'($signed(rs1) < $signed(issueIn.imm));
            SLTIU: resData = DataW'(rs1 < issueIn.imm);
            XORI:  resData = rs1 ^ issueIn.imm;
            ORI:   resData = rs1 | issueIn.imm;
            ANDI:  resData = rs1 & issueIn.imm;
            SLLI:  resData = rs1 << immShamt;
            SRLI:  resData = rs1 >> immShamt;
            SRAI:  resData = $signed(rs1) >>> immShamt;
            ADD:   resData = rs1 + rs2;
            SUB:   resData = rs1 - rs2;
            SLL:   resData = rs1 << regShamt;
            SLT:   resData = DataW'($signed(rs1) < $signed(rs2));
            SLTU:  resData = DataW'(rs1 < rs2);
            XOR:   resData = rs1 ^ rs2;
            SRL:   resData = rs1 >> regShamt;
            SRA:   resData = $signed(rs1) >>> regShamt;
            OR:    resData = rs1 | rs2;
            AND:   resData = rs1 & rs2;
            default: resData = '0;
        endcase
    end

    // Result register. A stall holds the last broadcast.
    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (rdy) begin
            validQ <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueValid) begin
            nickQ   <= issueIn.rd;
            dataQ   <= resData;
            takenQ  <= resTaken;
            targetQ <= resTarget;
        end
    end

    assign cdbOut = '{
        valid:  validQ,
        nick:   nickQ,
        data:   dataQ,
        taken:  takenQ,
        target: targetQ
    };

endmodule

`default_nettype wire

// ==== src/reservationStation.sv ====
`include "exec_defs.svh"

`timescale 1ns/1ps
`default_nettype none

module reservationStation
    import execPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,
    input  logic      dispatchValid,
    input  dispatch_t dispatchIn,
    output logic      dispatchReady,
    input  cdb_t      localCdb,
    input  cdb_t      extCdb,
    output logic      issueValid,
    output issue_t    issueOut
);

    localparam int Depth = `RS_DEPTH;
    localparam int IdxW = $clog2(Depth);

    dispatch_t        entry [Depth];
    logic [Depth-1:0] busy;
    logic [IdxW-1:0]  age [Depth];
    logic [IdxW-1:0]  ageNext [Depth];

    logic             freeFound;
    logic [IdxW-1:0]  freeIdx;
    logic             issueFound;
    logic [IdxW-1:0]  issuePick;
    logic             accept;
    dispatch_t        incoming;

    // Capture a waiting operand from whichever bus carries its nickname.
    function automatic operand_t wake(input operand_t op, input cdb_t busA, input cdb_t busB);
        operand_t res;
        res = op;
        if (!op.ready && busA.valid && busA.nick == op.nick) begin
            res.ready = 1'b1;
            res.data  = busA.data;
        end else if (!op.ready && busB.valid && busB.nick == op.nick) begin
            res.ready = 1'b1;
            res.data  = busB.data;
        end
        return res;
    endfunction

    ////////////////////////////////////////
    // Dispatch side
    ////////////////////////////////////////

    // An entry written this cycle also sees both buses.
    always_comb begin
        incoming     = dispatchIn;
        incoming.rs1 = wake(dispatchIn.rs1, localCdb, extCdb);
        incoming.rs2 = wake(dispatchIn.rs2, localCdb, extCdb);
    end

    // Lowest free slot.
    always_comb begin
        freeFound = 1'b0;
        freeIdx   = '0;
        for (int i = 0; i < Depth; i++) begin
            if (!busy[i] && !freeFound) begin
                freeFound = 1'b1;
                freeIdx   = IdxW'(i);
            end
        end
    end

    assign dispatchReady = freeFound;
    assign accept = dispatchValid && freeFound && rdy;

    ////////////////////////////////////////
    // Issue selection
    ////////////////////////////////////////

    // Oldest ready entry has the largest age.
    always_comb begin
        issueFound = 1'b0;
        issuePick  = '0;
        for (int i = 0; i < Depth; i++) begin
            if (busy[i] && entry[i].rs1.ready && entry[i].rs2.ready &&
                (!issueFound || age[i] > age[issuePick])) begin
                issueFound = 1'b1;
                issuePick  = IdxW'(i);
            end
        end
    end

    // Ages stay packed in 0..count-1: a dispatch pushes everyone older,
    // an issue pulls in the entries older than the one leaving.
    always_comb begin
        for (int i = 0; i < Depth; i++) begin
            ageNext[i] = age[i] + IdxW'(accept);
            if (issueFound && age[i] > age[issuePick]) begin
                ageNext[i] = ageNext[i] - 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // State
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= '0;
            issueValid <= 1'b0;
            for (int i = 0; i < Depth; i++) begin
                age[i] <= '0;
            end
        end else if (rdy) begin
            issueValid <= issueFound;
            for (int i = 0; i < Depth; i++) begin
                if (busy[i]) begin
                    age[i] <= ageNext[i];
                end
            end
            if (issueFound) begin
                busy[issuePick] <= 1'b0;
            end
            if (accept) begin
                busy[freeIdx] <= 1'b1;
                age[freeIdx]  <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            // Bus wakeup.
            for (int i = 0; i < Depth; i++) begin
                entry[i].rs1 <= wake(entry[i].rs1, localCdb, extCdb);
                entry[i].rs2 <= wake(entry[i].rs2, localCdb, extCdb);
            end
            if (accept) begin
                entry[freeIdx] <= incoming;
            end
            if (issueFound) begin
                issueOut <= '{
                    pc:      entry[issuePick].pc,
                    op:      entry[issuePick].op,
                    imm:     entry[issuePick].imm,
                    rd:      entry[issuePick].rd,
                    rs1Data: entry[issuePick].rs1.data,
                    rs2Data: entry[issuePick].rs2.data
                };
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/execPkg.sv ====
`include "exec_defs.svh"

`default_nettype none

package execPkg;

    parameter int DataW = `DATA_W;
    parameter int NickW = `NICK_W;

    // Decoded integer operations.
    typedef enum logic [5:0] {
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } aluOp_e;

    // Source operand. With ready clear, nick names the awaited result.
    typedef struct packed {
        logic             ready;
        logic [NickW-1:0] nick;
        logic [DataW-1:0] data;
    } operand_t;

    typedef struct packed {
        logic [DataW-1:0] pc;
        aluOp_e           op;
        logic [DataW-1:0] imm;
        logic [NickW-1:0] rd;
        operand_t         rs1;
        operand_t         rs2;
    } dispatch_t;

    typedef struct packed {
        logic [DataW-1:0] pc;
        aluOp_e           op;
        logic [DataW-1:0] imm;
        logic [NickW-1:0] rd;
        logic [DataW-1:0] rs1Data;
        logic [DataW-1:0] rs2Data;
    } issue_t;

    // One result on a common data bus.
    typedef struct packed {
        logic             valid;
        logic [NickW-1:0] nick;
        logic [DataW-1:0] data;
        logic             taken;
        logic [DataW-1:0] target;
    } cdb_t;

endpackage

`default_nettype wire

// ==== src/exec_defs.svh ====
`default_nettype none

`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Operand, pc and immediate width.
`define DATA_W 32

// Reorder-buffer tag width, used as the result nickname.
`define NICK_W 4

////////////////////////////////////////
// Reservation station
////////////////////////////////////////

// Number of station entries. Keep it a power of two.
`define RS_DEPTH 8

`endif

`default_nettype wire
